//--- common/conv_pkg.sv
package conv_pkg;

	// ####################
	// widths and counts.
	// ####################
	localparam int DATA_WIDTH = 32;
	localparam int KERNEL_TAPS = 25;
	localparam int TREE_LEVELS = 5;

	// one product stage plus one stage per tree level.
	localparam int CONV_LATENCY = 6;

	// ####################
	// types.
	// ####################
	typedef logic [DATA_WIDTH-1:0] fp32_t;
	typedef logic [$clog2(KERNEL_TAPS)-1:0] tap_addr_t;
	typedef fp32_t fp32_taps_t [KERNEL_TAPS];

	// nodes left after a given tree level, rounding up at each halving.
	function automatic int tree_width(input int level);
		return (KERNEL_TAPS + (1 << level) - 1) >> level;
	endfunction

endpackage

//--- conv/float_multiplier.sv
`timescale 1ns/1ps

module float_multiplier (
	input conv_pkg::fp32_t a,
	input conv_pkg::fp32_t b,
	output conv_pkg::fp32_t product
);

	logic sign;
	logic [7:0] exp_a;
	logic [7:0] exp_b;
	logic [23:0] man_a;
	logic [23:0] man_b;
	logic [47:0] man_prod;
	logic norm;
	logic [9:0] exp_sum;
	logic [22:0] frac;
	logic flush;

	// ####################
	// unpack.
	// ####################
	assign exp_a = a[30:23];
	assign exp_b = b[30:23];
	assign man_a = {1'b1, a[22:0]};
	assign man_b = {1'b1, b[22:0]};

	assign sign = a[31] ^ b[31];

	// ####################
	// significand product.
	// ####################
	assign man_prod = man_a * man_b;

	// product of two 1.x values lies in [1, 4), so at most one shift.
	assign norm = man_prod[47];
	assign frac = norm ? man_prod[46:24] : man_prod[45:23];

	// rebias, with the carry out of the product folded in.
	assign exp_sum = {2'b00, exp_a} + {2'b00, exp_b} + {9'd0, norm} - 10'd127;

	// zero or denormal inputs and exponent underflow all give +0.
	assign flush = (exp_a == 8'd0) || (exp_b == 8'd0) || exp_sum[9] || (exp_sum == 10'd0);

	assign product = flush ? '0 : {sign, exp_sum[7:0], frac};

endmodule

//--- conv/float_adder.sv
`timescale 1ns/1ps

module float_adder (
	input conv_pkg::fp32_t a,
	input conv_pkg::fp32_t b,
	output conv_pkg::fp32_t sum
);

	logic zero_a;
	logic zero_b;
	logic [30:0] mag_a;
	logic [30:0] mag_b;
	logic a_big;
	logic sign_big;
	logic [7:0] exp_big;
	logic [7:0] exp_small;
	logic [7:0] exp_diff;
	logic [23:0] man_big;
	logic [23:0] man_small;
	logic [23:0] man_shift;
	logic [24:0] man_sum;
	logic [4:0] lead_zeros;
	logic [23:0] man_norm;
	logic [8:0] exp_norm;
	logic result_zero;

	// ####################
	// flush and order.
	// ####################
	assign zero_a = (a[30:23] == 8'd0);
	assign zero_b = (b[30:23] == 8'd0);
	assign mag_a = zero_a ? 31'd0 : a[30:0];
	assign mag_b = zero_b ? 31'd0 : b[30:0];

	// exponent sits above the fraction, so one compare orders magnitudes.
	assign a_big = (mag_a >= mag_b);

	assign sign_big = a_big ? a[31] : b[31];
	assign exp_big = a_big ? mag_a[30:23] : mag_b[30:23];
	assign exp_small = a_big ? mag_b[30:23] : mag_a[30:23];
	assign man_big = a_big ? {~zero_a, mag_a[22:0]} : {~zero_b, mag_b[22:0]};
	assign man_small = a_big ? {~zero_b, mag_b[22:0]} : {~zero_a, mag_a[22:0]};

	// ####################
	// align and add.
	// ####################
	assign exp_diff = exp_big - exp_small;

	// bits shifted out are simply dropped.
	assign man_shift = man_small >> exp_diff;

	// big operand has the larger magnitude, so the difference never goes negative.
	assign man_sum = (a[31] == b[31]) ? ({1'b0, man_big} + {1'b0, man_shift})
		: ({1'b0, man_big} - {1'b0, man_shift});

	// ####################
	// normalize.
	// ####################
	always_comb
	begin
		lead_zeros = 5'd0;
		for (int i = 0; i < 24; i++)
		begin
			if (man_sum[i])
				lead_zeros = 5'(23 - i);
		end
	end

	always_comb
	begin
		if (man_sum[24])
		begin
			man_norm = man_sum[24:1];
			exp_norm = {1'b0, exp_big} + 9'd1;
		end
		else
		begin
			man_norm = man_sum[23:0] << lead_zeros;
			exp_norm = {1'b0, exp_big} - {4'd0, lead_zeros};
		end
	end

	// exact cancellation and underflow both land on +0.
	assign result_zero = (man_sum == 25'd0) || exp_norm[8] || (exp_norm == 9'd0);

	assign sum = result_zero ? '0 : {sign_big, exp_norm[7:0], man_norm[22:0]};

endmodule

//--- conv/conv_unit.sv
`timescale 1ns/1ps

module conv_unit (
	input logic clk,
	input logic reset,
	input logic issue,
	input conv_pkg::fp32_taps_t weights,
	input conv_pkg::fp32_taps_t pixels,
	output conv_pkg::fp32_t sum,
	output logic sum_valid
);

	import conv_pkg::*;

	fp32_taps_t products;
	fp32_taps_t product_q;
	logic [CONV_LATENCY-1:0] valid_pipe;

	genvar lvl;
	genvar idx;

	// ####################
	// multipliers.
	// ####################
	for (idx = 0; idx < KERNEL_TAPS; idx++)
	begin : g_mul
		float_multiplier u_mul (
			.a(weights[idx]),
			.b(pixels[idx]),
			.product(products[idx])
		);
	end

	// operands are taken only on issue.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			product_q <= '{default: '0};
		else if (issue)
			product_q <= products;
	end

	// ####################
	// adder tree.
	// ####################
	for (lvl = 0; lvl < TREE_LEVELS; lvl++)
	begin : g_level
		fp32_t node_in [tree_width(lvl)];
		fp32_t node_d [tree_width(lvl + 1)];
		fp32_t node_q [tree_width(lvl + 1)];

		if (lvl == 0)
		begin : g_src
			assign node_in = product_q;
		end
		else
		begin : g_src
			assign node_in = g_level[lvl-1].node_q;
		end

		for (idx = 0; idx < tree_width(lvl + 1); idx++)
		begin : g_node
			if (2 * idx + 1 < tree_width(lvl))
			begin : g_add
				float_adder u_add (
					.a(node_in[2*idx]),
					.b(node_in[2*idx+1]),
					.sum(node_d[idx])
				);
			end
			else
			begin : g_pass
				// odd last node skips this level.
				assign node_d[idx] = node_in[2*idx];
			end

			always_ff @(posedge clk or posedge reset)
			begin
				if (reset)
					node_q[idx] <= '0;
				else
					node_q[idx] <= node_d[idx];
			end
		end
	end

	assign sum = g_level[TREE_LEVELS-1].node_q[0];

	// tracks which tree output holds a real result.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[CONV_LATENCY-2:0], issue};
	end

	assign sum_valid = valid_pipe[CONV_LATENCY-1];

endmodule

//--- design/operand_bank.sv
`timescale 1ns/1ps

module operand_bank (
	input logic clk,
	input logic reset,
	input logic we,
	input conv_pkg::tap_addr_t addr,
	input conv_pkg::fp32_t data,
	output conv_pkg::fp32_taps_t taps
);

	import conv_pkg::*;

	logic addr_ok;

	// the address space reaches past the last tap.
	assign addr_ok = (addr < KERNEL_TAPS);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			taps <= '{default: '0};
		else if (we && addr_ok)
			taps[addr] <= data;
	end

endmodule

//--- design/conv_top.sv
`timescale 1ns/1ps

module conv_top (
	input logic clk,
	input logic reset,
	input logic wt_we,
	input conv_pkg::tap_addr_t wt_addr,
	input conv_pkg::fp32_t wt_data,
	input logic px_we,
	input conv_pkg::tap_addr_t px_addr,
	input conv_pkg::fp32_t px_data,
	input logic issue,
	output conv_pkg::fp32_t result,
	output logic result_valid
);

	import conv_pkg::*;

	fp32_taps_t weight_taps;
	fp32_taps_t pixel_taps;

	// ####################
	// operand banks.
	// ####################
	operand_bank weight_bank (
		.clk(clk),
		.reset(reset),
		.we(wt_we),
		.addr(wt_addr),
		.data(wt_data),
		.taps(weight_taps)
	);

	operand_bank pixel_bank (
		.clk(clk),
		.reset(reset),
		.we(px_we),
		.addr(px_addr),
		.data(px_data),
		.taps(pixel_taps)
	);

	// ####################
	// convolution.
	// ####################
	conv_unit u_conv_unit (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.weights(weight_taps),
		.pixels(pixel_taps),
		.sum(result),
		.sum_valid(result_valid)
	);

endmodule

//--- verif/conv_assert.sv
`timescale 1ns/1ps

module conv_assert (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic sum_valid
);

	import conv_pkg::*;

	// count of failed assertions.
	int error_count = 0;

	// the valid pipe is cleared while reset is held.
	assert property (@(posedge clk) reset |-> !sum_valid)
		else
		begin
			error_count++;
			$error("sum_valid high during reset");
		end

	assert property (@(posedge clk) disable iff (reset)
		issue |-> ##CONV_LATENCY sum_valid)
		else
		begin
			error_count++;
			$error("issue not followed by sum_valid after the pipeline latency");
		end

	// no result without a matching issue.
	assert property (@(posedge clk) disable iff (reset)
		sum_valid |-> $past(issue, CONV_LATENCY))
		else
		begin
			error_count++;
			$error("sum_valid without an issue at the pipeline latency");
		end

endmodule

bind conv_unit conv_assert u_conv_assert (
	.clk(clk),
	.reset(reset),
	.issue(issue),
	.sum_valid(sum_valid)
);

//--- verif/conv_tb.sv
`timescale 1ns/1ps

module conv_tb;

	import conv_pkg::*;

	localparam string TEST_FILE = "verif/conv_tests.txt";

	logic clk;
	logic reset;
	logic wt_we;
	tap_addr_t wt_addr;
	fp32_t wt_data;
	logic px_we;
	tap_addr_t px_addr;
	fp32_t px_data;
	logic issue;
	fp32_t result;
	logic result_valid;

	string lines [$];
	string name_q [$];
	fp32_t expect_q [$];
	int line_total = 0;
	int timeout_cycles = 0;

	conv_top dut (
		.clk(clk),
		.reset(reset),
		.wt_we(wt_we),
		.wt_addr(wt_addr),
		.wt_data(wt_data),
		.px_we(px_we),
		.px_addr(px_addr),
		.px_data(px_data),
		.issue(issue),
		.result(result),
		.result_valid(result_valid)
	);

	always #4 clk = ~clk;

	// ####################
	// checks.
	// ####################
	task automatic check_fp32(input string name, input fp32_t expected, input fp32_t actual);
		if (actual !== expected)
		begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "result mismatch");
		end
	endtask

	task automatic check_logic(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("FAIL %s: expected %b, actual %b", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	always @(dut.u_conv_unit.u_conv_assert.error_count)
	begin
		if (dut.u_conv_unit.u_conv_assert.error_count != 0)
			stop_on_error("an assertion on the valid pipeline failed");
	end

	// ####################
	// stimulus.
	// ####################

	// small positive integers only.
	function automatic fp32_t int_to_fp32(input int value);
		int msb;
		logic [31:0] mag;
		msb = 0;
		mag = value;
		for (int i = 0; i < 32; i++)
		begin
			if (mag[i])
				msb = i;
		end
		return {1'b0, 8'(127 + msb), 23'(mag << (23 - msb))};
	endfunction

	task automatic clear_strobes();
		wt_we = 1'b0;
		px_we = 1'b0;
		issue = 1'b0;
	endtask

	task automatic write_tap(input string bank, input int addr, input fp32_t value);
		if (bank == "W")
		begin
			wt_we = 1'b1;
			wt_addr = tap_addr_t'(addr);
			wt_data = value;
		end
		else
		begin
			px_we = 1'b1;
			px_addr = tap_addr_t'(addr);
			px_data = value;
		end
	endtask

	task automatic load_tests();
		int fd;
		int got;
		string text;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0)
			stop_on_error("could not open the test file");
		while (!$feof(fd))
		begin
			text = "";
			got = $fgets(text, fd);
			if (got > 0)
				line_total++;
			if (got > 0 && text.len() > 1 && text.getc(0) != "#")
				lines.push_back(text);
		end
		$fclose(fd);
	endtask

	// one line of the test file; step 0 keeps the strobes for the next line's edge.
	task automatic run_line(input string text);
		string kind;
		string field;
		fp32_t value;
		int step;
		int count;
		count = $sscanf(text, "%s %s %h %d", kind, field, value, step);
		if (count != 4)
			stop_on_error({"malformed line in the test file: ", text});
		if (kind == "W" || kind == "P")
			write_tap(kind, field.atoi(), value);
		else if (kind == "F" || kind == "R")
		begin
			for (int i = 0; i < KERNEL_TAPS; i++)
			begin
				write_tap(field, i, (kind == "F") ? value : int_to_fp32(i + 1));
				@(negedge clk);
			end
			clear_strobes();
			step = 0;
		end
		else if (kind == "I")
		begin
			issue = 1'b1;
			name_q.push_back(field);
			expect_q.push_back(value);
		end
		else
			stop_on_error({"unknown command in the test file: ", text});
		if (step != 0)
		begin
			@(negedge clk);
			clear_strobes();
		end
	endtask

	// ####################
	// result monitor.
	// ####################
	always @(negedge clk)
	begin
		if (!reset && result_valid)
		begin
			if (expect_q.size() == 0)
				stop_on_error("result_valid went high with no issue pending");
			else
				check_fp32(name_q.pop_front(), expect_q.pop_front(), result);
		end
	end

	// budget grows with the length of the test file.
	initial
	begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clk);
		$display("watchdog timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		wt_addr = '0;
		wt_data = '0;
		px_addr = '0;
		px_data = '0;
		clear_strobes();
		load_tests();
		timeout_cycles = 20 * line_total + 100;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_logic("reset_valid", 1'b0, result_valid);
		check_fp32("reset_result", '0, result);
		foreach (lines[i])
			run_line(lines[i]);
		for (int i = 0; i < CONV_LATENCY + 2 && expect_q.size() != 0; i++)
			@(negedge clk);
		repeat (2) @(negedge clk);
		if (expect_q.size() == 0)
		begin
			$display("Simulation completed successfully");
			$finish;
		end
		else
		begin
			$display("%0d issued results never came back", expect_q.size());
			$display("Simulation failed");
			$fatal(1, "missing results");
		end
	end

endmodule

//--- verif/conv_tests.txt
# columns: kind field value_hex step
# W/P tap write (field = address), F fill bank, R ramp bank 1.0..25.0, I issue (field = test name)
F W 3f800000 1
R P 0 1
I ramp_sum 43a28000 1
W 0 bf800000 1
I signed_sum 43a18000 1
F P 00000000 1
P 0 40000000 1
P 1 40000000 1
I cancel_zero 00000000 1
P 1 00000001 1
P 2 40400000 1
I denormal_px 3f800000 1
F W 00000000 1
I zero_bank 00000000 1
F W 3f000000 1
F P 3e800000 1
I frac_fill 40480000 1
P 0 40000000 1
I frac_mix 40800000 1
I b2b_first 40800000 0
P 0 40800000 1
I b2b_second 40a00000 0
P 1 00000000 1
I b2b_third 409c0000 1
W 25 40000000 1
P 31 40000000 1
I bad_addr 409c0000 1

//--- files.f
common/conv_pkg.sv
conv/float_multiplier.sv
conv/float_adder.sv
conv/conv_unit.sv
design/operand_bank.sv
design/conv_top.sv
verif/conv_assert.sv
verif/conv_tb.sv
